//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_axi_fifo_bridge
FILELIST  := axi_fifo_bridge.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) verif/axi_fifo_bridge_vectors.txt
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

//--- axi_fifo_bridge.f
src/axi_pkg.sv
src/bridge_pkg.sv
src/sync_fifo.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/axi_fifo_bridge.sv
verif/axi_fifo_bridge_props.sv
verif/tb_axi_fifo_bridge.sv

//--- src/axi_fifo_bridge.sv
`timescale 1ns/10ps

module axi_fifo_bridge
    import axi_pkg::*;
    import bridge_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4,
    parameter int FIFO_DEPTH = 16   // Power of two
) (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,
    // Write address
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [ID_WIDTH-1:0]       s_axi_awid,
    input  axi_len_t                  s_axi_awlen,   // Burst closes on wlast
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    // Write data
    input  logic [DATA_WIDTH-1:0]     s_axi_wdata,
    input  logic                      s_axi_wlast,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    // Write response
    output logic [ID_WIDTH-1:0]       s_axi_bid,
    output axi_resp_t                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    // Read address
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [ID_WIDTH-1:0]       s_axi_arid,
    input  axi_len_t                  s_axi_arlen,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    // Read data
    output logic [ID_WIDTH-1:0]       s_axi_rid,
    output logic [DATA_WIDTH-1:0]     s_axi_rdata,
    output axi_resp_t                 s_axi_rresp,
    output logic                      s_axi_rlast,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    // Outbound stream
    output logic [DATA_WIDTH-1:0]     sink_data,
    output logic                      sink_valid,
    input  logic                      sink_ready,
    // Inbound stream
    input  logic [DATA_WIDTH-1:0]     src_data,
    input  logic                      src_valid,
    output logic                      src_ready
);

    logic tx_push, tx_flush, tx_full, tx_empty;
    logic rx_pop, rx_flush, rx_full, rx_empty;
    logic [DATA_WIDTH-1:0] rx_data;

    // Control and status bits must fit in a data word
    if (DATA_WIDTH <= FLUSH_RX_BIT || DATA_WIDTH <= STATUS_RX_EMPTY_BIT) begin : g_width_check
        $error("DATA_WIDTH too narrow for the control and status words");
    end

    //////////////////////////////////////////////////
    // Stream glue
    //////////////////////////////////////////////////

    assign sink_valid = !tx_empty;
    assign src_ready  = !rx_full;

    axi_write_ctrl #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_write_ctrl (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_awaddr, .s_axi_awid, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wlast, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bid, .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .tx_full, .tx_push, .tx_flush, .rx_flush
    );

    axi_read_ctrl #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_read_ctrl (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_araddr, .s_axi_arid, .s_axi_arlen, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rid, .s_axi_rdata, .s_axi_rresp, .s_axi_rlast, .s_axi_rvalid, .s_axi_rready,
        .rx_empty, .rx_data, .rx_pop
    );

    // Bus to sink, fed straight from wdata
    sync_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .s_axi_aclk, .s_axi_aresetn,
        .flush(tx_flush), .push(tx_push), .wdata(s_axi_wdata),
        .pop(sink_valid && sink_ready), .rdata(sink_data),
        .full(tx_full), .empty(tx_empty)
    );

    // Source to bus
    sync_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .s_axi_aclk, .s_axi_aresetn,
        .flush(rx_flush), .push(src_valid && src_ready), .wdata(src_data),
        .pop(rx_pop), .rdata(rx_data),
        .full(rx_full), .empty(rx_empty)
    );

endmodule

//--- src/axi_pkg.sv
package axi_pkg;

    //////////////////////////////////////////////////
    // Bus field widths
    //////////////////////////////////////////////////

    localparam int AXI_ADDR_WIDTH = 6;   // Byte address into the bridge window
    localparam int AXI_LEN_WIDTH  = 8;   // AxLEN, beats minus one

    // Beat count as carried on AxLEN
    typedef logic [AXI_LEN_WIDTH-1:0] axi_len_t;

    //////////////////////////////////////////////////
    // Response codes
    //////////////////////////////////////////////////

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;   // Slave error, unmapped or no data

endpackage

//--- src/axi_read_ctrl.sv
`timescale 1ns/10ps

module axi_read_ctrl
    import axi_pkg::*;
    import bridge_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,

    // Read address
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [ID_WIDTH-1:0]       s_axi_arid,
    input  axi_len_t                  s_axi_arlen,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,

    // Read data
    output logic [ID_WIDTH-1:0]       s_axi_rid,
    output logic [DATA_WIDTH-1:0]     s_axi_rdata,
    output axi_resp_t                 s_axi_rresp,
    output logic                      s_axi_rlast,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,

    // Inbound FIFO
    input  logic                      rx_empty,
    input  logic [DATA_WIDTH-1:0]     rx_data,     // Head word
    output logic                      rx_pop
);

    typedef enum logic {
        RD_IDLE,
        RD_BEATS
    } rd_state_t;

    typedef enum logic [1:0] {
        MODE_DATA,   // FIFO head per beat
        MODE_STAT,   // Status word per beat
        MODE_ERR     // Zero data, SLVERR
    } rd_mode_t;

    rd_state_t             state;
    rd_mode_t              mode;
    axi_len_t              beats_left;   // Beats after the current one
    logic [ID_WIDTH-1:0]   id_q;
    logic                  empty_q;      // rx_empty seen at AR time
    addr_target_t          ar_tgt;
    logic                  ar_fire;
    logic                  r_fire;
    logic [DATA_WIDTH-1:0] status_word;

    //////////////////////////////////////////////////
    // Handshakes and beat contents
    //////////////////////////////////////////////////

    assign ar_tgt        = decode_addr(s_axi_araddr, 1'b0);
    assign s_axi_arready = (state == RD_IDLE);
    assign ar_fire       = s_axi_arvalid && s_axi_arready;

    // Data beats wait for a word, the other modes never stall
    assign s_axi_rvalid = (state == RD_BEATS) && ((mode != MODE_DATA) || !rx_empty);
    assign r_fire       = s_axi_rvalid && s_axi_rready;
    assign rx_pop       = r_fire && (mode == MODE_DATA);

    assign s_axi_rlast = (state == RD_BEATS) && (beats_left == '0);
    assign s_axi_rid   = id_q;
    assign s_axi_rresp = (mode == MODE_ERR) ? RESP_SLVERR : RESP_OKAY;

    always_comb begin
        status_word                      = '0;
        status_word[STATUS_RX_EMPTY_BIT] = empty_q;
    end

    // Head is stable until popped, so rdata holds under rready low
    always_comb begin
        case (mode)
            MODE_DATA: s_axi_rdata = rx_data;
            MODE_STAT: s_axi_rdata = status_word;
            default:   s_axi_rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Burst FSM
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state      <= RD_IDLE;
            mode       <= MODE_ERR;
            beats_left <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        beats_left <= s_axi_arlen;
                        state      <= RD_BEATS;   // First rvalid next cycle
                        case (ar_tgt)
                            TGT_FIFO: mode <= rx_empty ? MODE_ERR : MODE_DATA;
                            TGT_REG:  mode <= MODE_STAT;
                            default:  mode <= MODE_ERR;
                        endcase
                    end
                end
                RD_BEATS: begin
                    if (r_fire) begin
                        if (beats_left == '0) begin
                            state <= RD_IDLE;   // rlast beat taken
                        end else begin
                            beats_left <= beats_left - 1'b1;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            id_q    <= s_axi_arid;
            empty_q <= rx_empty;   // Status snapshot for the whole burst
        end
    end

endmodule

//--- src/axi_write_ctrl.sv
`timescale 1ns/10ps

module axi_write_ctrl
    import axi_pkg::*;
    import bridge_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,

    // Write address
    input  logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [ID_WIDTH-1:0]       s_axi_awid,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,

    // Write data
    input  logic [DATA_WIDTH-1:0]     s_axi_wdata,
    input  logic                      s_axi_wlast,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,

    // Write response
    output logic [ID_WIDTH-1:0]       s_axi_bid,
    output axi_resp_t                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,

    // FIFO side
    input  logic                      tx_full,
    output logic                      tx_push,     // Same cycle as the W beat
    output logic                      tx_flush,    // One-cycle pulse
    output logic                      rx_flush     // One-cycle pulse
);

    typedef enum logic [1:0] {
        WR_IDLE,     // Waiting on AW
        WR_DATA,     // Taking W beats until wlast
        WR_RESP      // Holding B until bready
    } wr_state_t;

    wr_state_t           state;
    addr_target_t        tgt_q;      // Target of the open burst
    logic [ID_WIDTH-1:0] id_q;
    logic                aw_fire;
    logic                w_fire;
    logic                reg_beat;

    //////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////

    assign s_axi_awready = (state == WR_IDLE);
    assign aw_fire       = s_axi_awvalid && s_axi_awready;

    // Only FIFO beats can stall, control and unmapped beats always go through
    assign s_axi_wready = (state == WR_DATA) && ((tgt_q != TGT_FIFO) || !tx_full);
    assign w_fire       = s_axi_wvalid && s_axi_wready;

    assign tx_push  = w_fire && (tgt_q == TGT_FIFO);
    assign reg_beat = w_fire && (tgt_q == TGT_REG);

    // Response follows the latched target
    assign s_axi_bvalid = (state == WR_RESP);
    assign s_axi_bresp  = (tgt_q == TGT_NONE) ? RESP_SLVERR : RESP_OKAY;
    assign s_axi_bid    = id_q;

    //////////////////////////////////////////////////
    // Burst FSM
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= WR_IDLE;
            tgt_q <= TGT_NONE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        tgt_q <= decode_addr(s_axi_awaddr, 1'b1);
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    // Unmapped beats are dropped here too, burst still closes on wlast
                    if (w_fire && s_axi_wlast) begin
                        state <= WR_RESP;   // bvalid next cycle
                    end
                end
                WR_RESP: begin
                    if (s_axi_bready) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            id_q <= s_axi_awid;   // Echoed on bid
        end
    end

    // Control beat to flush pulses, high the cycle after the beat
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            tx_flush <= 1'b0;
            rx_flush <= 1'b0;
        end else begin
            tx_flush <= reg_beat && s_axi_wdata[FLUSH_TX_BIT];
            rx_flush <= reg_beat && s_axi_wdata[FLUSH_RX_BIT];
        end
    end

endmodule

//--- src/bridge_pkg.sv
package bridge_pkg;

    import axi_pkg::*;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    localparam logic [AXI_ADDR_WIDTH-1:0] FIFO_ADDR   = 6'h00;  // Data window, both directions
    localparam logic [AXI_ADDR_WIDTH-1:0] CTRL_ADDR   = 6'h10;  // Write side
    localparam logic [AXI_ADDR_WIDTH-1:0] STATUS_ADDR = 6'h10;  // Read side

    // Control word
    localparam int FLUSH_TX_BIT = 0;   // Empty the outbound FIFO
    localparam int FLUSH_RX_BIT = 1;   // Empty the inbound FIFO

    // Status word
    localparam int STATUS_RX_EMPTY_BIT = 0;

    typedef enum logic [1:0] {
        TGT_FIFO,
        TGT_REG,
        TGT_NONE
    } addr_target_t;

    // Map a burst address onto its target, register address depends on direction
    function automatic addr_target_t decode_addr(input logic [AXI_ADDR_WIDTH-1:0] addr,
                                                 input logic is_write);
        logic [AXI_ADDR_WIDTH-1:0] reg_addr;
        reg_addr = is_write ? CTRL_ADDR : STATUS_ADDR;
        if (addr == FIFO_ADDR)
            return TGT_FIFO;
        return (addr == reg_addr) ? TGT_REG : TGT_NONE;
    endfunction

endpackage

//--- src/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16      // Power of two
) (
    input  logic             s_axi_aclk,
    input  logic             s_axi_aresetn,
    input  logic             flush,        // Drop all contents
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,        // Head word, shown ahead
    output logic             full,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = DEPTH[AW:0];

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;     // Occupancy, one extra bit for full

    //////////////////////////////////////////////////
    // Flags and head
    //////////////////////////////////////////////////

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign rdata = mem[rd_ptr];   // Valid whenever empty is low

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin  // Flush beats push and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

endmodule

//--- verif/axi_fifo_bridge_props.sv
`timescale 1ns/10ps

module axi_fifo_bridge_props #(
    parameter int DATA_WIDTH = 32
) (
    input logic                  s_axi_aclk,
    input logic                  s_axi_aresetn,
    input logic                  s_axi_bvalid,
    input logic                  s_axi_bready,
    input logic                  s_axi_rvalid,
    input logic                  s_axi_rready,
    input logic [DATA_WIDTH-1:0] s_axi_rdata,
    input logic                  s_axi_rlast,
    input logic                  tx_push,
    input logic                  tx_full,
    input logic                  rx_pop,
    input logic                  rx_empty
);

    //////////////////////////////////////////////////
    // Handshake stability
    //////////////////////////////////////////////////

    // Response stays up until taken
    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // Stalled beat keeps its payload
    a_rbeat_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
                                          && $stable(s_axi_rlast))
        else $error("R beat changed while rready low");

    //////////////////////////////////////////////////
    // FIFO bounds
    //////////////////////////////////////////////////

    a_no_overflow: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(tx_push && tx_full))
        else $error("push into full outbound FIFO");

    a_no_underflow: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(rx_pop && rx_empty))
        else $error("pop from empty inbound FIFO");

endmodule

bind axi_fifo_bridge axi_fifo_bridge_props #(.DATA_WIDTH(DATA_WIDTH)) u_props (
    .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn),
    .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
    .s_axi_rdata(s_axi_rdata), .s_axi_rlast(s_axi_rlast),
    .tx_push(tx_push), .tx_full(tx_full), .rx_pop(rx_pop), .rx_empty(rx_empty)
);

//--- verif/axi_fifo_bridge_vectors.txt
# op addr len id data resp (hex); op 1 write, 2 read, 3 source push len words,
# 4 sink hold (len>0 releases after len cycles), 5 release, 6 drain, 7 sink idle len cycles
1 00 03 3 a0000000 0
6 00 00 0 00000000 0
3 00 08 0 00000000 0
2 00 07 5 00000000 0
2 10 00 1 00000001 0
3 00 01 0 00000000 0
2 10 00 2 00000000 0
2 00 00 2 00000000 0
4 00 00 0 00000000 0
1 00 02 6 b0000000 0
1 10 00 7 00000001 0
7 00 05 0 00000000 0
5 00 00 0 00000000 0
3 00 02 0 00000000 0
1 10 00 8 00000002 0
2 10 00 9 00000001 0
1 08 01 a c0000000 2
2 08 02 b 00000000 2
2 00 00 c 00000000 2
4 00 28 0 00000000 0
1 00 13 d d0000000 0
6 00 00 0 00000000 0

//--- verif/tb_axi_fifo_bridge.sv
`timescale 1ns/10ps

module tb_axi_fifo_bridge
    import axi_pkg::*;
    import bridge_pkg::*;
();

    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int FIFO_DEPTH = 16;
    localparam int TIMEOUT    = 200;   // Cycles per wait

    logic                      s_axi_aclk, s_axi_aresetn;
    logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr, s_axi_araddr;
    logic [ID_WIDTH-1:0]       s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
    axi_len_t                  s_axi_awlen, s_axi_arlen;
    logic                      s_axi_awvalid, s_axi_awready, s_axi_arvalid, s_axi_arready;
    logic [DATA_WIDTH-1:0]     s_axi_wdata, s_axi_rdata, sink_data, src_data;
    logic                      s_axi_wlast, s_axi_wvalid, s_axi_wready;
    axi_resp_t                 s_axi_bresp, s_axi_rresp;
    logic                      s_axi_bvalid, s_axi_bready;
    logic                      s_axi_rlast, s_axi_rvalid, s_axi_rready;
    logic                      sink_valid, sink_ready, src_valid, src_ready;

    logic [31:0] sink_q[$];   // Words the sink still expects
    logic [31:0] src_q[$];    // Words sitting in the inbound FIFO
    integer      seed;
    int          errors, checks, hold_cycles;
    bit          timed_out;   // Once set, every wait returns and the run winds down

    axi_fifo_bridge #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH), .FIFO_DEPTH(FIFO_DEPTH))
        dut_i (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #10 s_axi_aclk = ~s_axi_aclk;
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic note_timeout(string what);
        errors++;
        timed_out = 1'b1;
        $display("Timed out waiting for %s", what);
    endtask

    function automatic logic probe(int sel);
        case (sel)
            0:       return s_axi_awready;
            1:       return s_axi_wready;
            2:       return s_axi_bvalid;
            3:       return s_axi_arready;
            default: return src_ready;
        endcase
    endfunction

    // Called just after a falling-edge drive, returns mid low phase with the signal high
    task automatic wait_cond(int sel, string what);
        int n;
        n = 0;
        #2;
        while (!probe(sel) && !timed_out) begin
            if (n >= TIMEOUT) begin
                note_timeout(what);
            end else begin
                @(negedge s_axi_aclk);
                #2;
                n++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////

    task automatic axi_write(string name, logic [5:0] addr, axi_len_t len, logic [3:0] id,
                             logic [31:0] base, axi_resp_t resp);
        if (addr == FIFO_ADDR && resp == RESP_OKAY) begin
            for (int k = 0; k <= int'(len); k++) sink_q.push_back(base + 32'(k));
        end
        @(negedge s_axi_aclk);
        s_axi_awaddr  = addr;
        s_axi_awid    = id;
        s_axi_awlen   = len;
        s_axi_awvalid = 1'b1;
        wait_cond(0, "awready");
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            s_axi_wdata  = base + 32'(beat);
            s_axi_wlast  = (beat == int'(len));
            s_axi_wvalid = 1'b1;
            wait_cond(1, "wready");
            @(negedge s_axi_aclk);
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        wait_cond(2, "bvalid");
        check_value({name, " bid"}, 32'(id), 32'(s_axi_bid));
        check_value({name, " bresp"}, 32'(resp), 32'(s_axi_bresp));
        @(negedge s_axi_aclk);   // B held one cycle with bready low
        s_axi_bready = 1'b1;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
        if (addr == CTRL_ADDR && resp == RESP_OKAY) begin   // Flush the models too
            if (base[FLUSH_TX_BIT]) sink_q.delete();
            if (base[FLUSH_RX_BIT]) src_q.delete();
        end
    endtask

    task automatic axi_read(string name, logic [5:0] addr, axi_len_t len, logic [3:0] id,
                            logic [31:0] status, axi_resp_t resp);
        int          beat;
        int          n;
        logic [31:0] rnd;
        logic [31:0] expected;
        @(negedge s_axi_aclk);
        s_axi_araddr  = addr;
        s_axi_arid    = id;
        s_axi_arlen   = len;
        s_axi_arvalid = 1'b1;
        wait_cond(3, "arready");
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        beat = 0;
        n    = 0;
        while (beat <= int'(len) && !timed_out) begin
            rnd          = $random(seed);
            s_axi_rready = (rnd[1:0] != 2'b00);   // Stall about a quarter of cycles
            #2;
            if (s_axi_rvalid && s_axi_rready) begin
                expected = '0;
                if (resp == RESP_OKAY && addr == STATUS_ADDR) begin
                    expected = status;
                end else if (resp == RESP_OKAY) begin
                    if (src_q.size() == 0) begin
                        errors++;
                        $display("** Error %s: read beat with no inbound word pending", name);
                    end else begin
                        expected = src_q.pop_front();
                    end
                end
                check_value($sformatf("%s rdata beat %0d", name, beat), expected, s_axi_rdata);
                check_value($sformatf("%s rresp beat %0d", name, beat), 32'(resp),
                            32'(s_axi_rresp));
                check_value($sformatf("%s rid beat %0d", name, beat), 32'(id), 32'(s_axi_rid));
                check_value($sformatf("%s rlast beat %0d", name, beat),
                            32'(beat == int'(len)), 32'(s_axi_rlast));
                beat++;
                n = 0;
            end else begin
                if (n >= TIMEOUT) note_timeout("rvalid");
                n++;
            end
            @(negedge s_axi_aclk);
        end
        s_axi_rready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Stream models
    //////////////////////////////////////////////////

    task automatic source_push(int count);
        @(negedge s_axi_aclk);
        for (int k = 0; k < count; k++) begin
            src_data  = $random(seed);
            src_valid = 1'b1;
            wait_cond(4, "src_ready");
            src_q.push_back(src_data);
            @(negedge s_axi_aclk);
        end
        src_valid = 1'b0;
    endtask

    // Sink checks every word it takes
    initial begin
        forever begin
            @(negedge s_axi_aclk);
            #3;
            if (sink_valid && sink_ready) begin
                if (sink_q.size() == 0) begin
                    errors++;
                    $display("** Error sink: word %h arrived with none expected", sink_data);
                end else begin
                    check_value("sink word", sink_q.pop_front(), sink_data);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Vector driver
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          lineno;
        int          n;
        string       line;
        string       name;
        logic [31:0] op, base;
        logic [5:0]  addr;
        axi_len_t    len;
        logic [3:0]  id;
        axi_resp_t   resp;
        seed = 32'he52d;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        {s_axi_awaddr, s_axi_awid, s_axi_awlen, s_axi_awvalid} = '0;
        {s_axi_wdata, s_axi_wlast, s_axi_wvalid, s_axi_bready} = '0;
        {s_axi_araddr, s_axi_arid, s_axi_arlen, s_axi_arvalid, s_axi_rready} = '0;
        {src_data, src_valid} = '0;
        sink_ready    = 1'b1;
        s_axi_aresetn = 1'b0;
        fd = $fopen("verif/axi_fifo_bridge_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vectors file");
        end
        repeat (3) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);
        #2;
        // Idle bus one cycle out of reset
        check_value("reset awready", 32'd1, 32'(s_axi_awready));
        check_value("reset arready", 32'd1, 32'(s_axi_arready));
        check_value("reset bvalid", 32'd0, 32'(s_axi_bvalid));
        check_value("reset rvalid", 32'd0, 32'(s_axi_rvalid));
        check_value("reset rlast", 32'd0, 32'(s_axi_rlast));
        check_value("reset sink_valid", 32'd0, 32'(sink_valid));
        lineno = 0;
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            lineno++;
            if ($fgets(line, fd) == 0) continue;
            if ($sscanf(line, "%h %h %h %h %h %h", op, addr, len, id, base, resp) != 6)
                continue;   // Comment or blank
            name = $sformatf("line %0d", lineno);
            case (op)
                1: axi_write(name, addr, len, id, base, resp);
                2: axi_read(name, addr, len, id, base, resp);
                3: source_push(int'(len));
                4: begin   // Hold sink, optional timed release
                    @(negedge s_axi_aclk);
                    sink_ready  = 1'b0;
                    hold_cycles = int'(len);
                    if (hold_cycles != 0) begin
                        fork
                            begin
                                repeat (hold_cycles) @(negedge s_axi_aclk);
                                sink_ready = 1'b1;
                            end
                        join_none
                    end
                end
                5: begin
                    @(negedge s_axi_aclk);
                    sink_ready = 1'b1;
                end
                6: begin   // Drain
                    n = 0;
                    while (sink_q.size() != 0 && !timed_out) begin
                        if (n >= TIMEOUT) note_timeout("sink drain");
                        @(negedge s_axi_aclk);
                        n++;
                    end
                end
                7: begin   // Sink must stay idle
                    repeat (int'(len)) begin
                        @(negedge s_axi_aclk);
                        #2;
                        check_value({name, " sink_valid"}, 32'd0, 32'(sink_valid));
                    end
                end
                default: begin
                    errors++;
                    $display("Unknown operation %0h on %s", op, name);
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        repeat (4) @(negedge s_axi_aclk);
        check_value("sink words left", 32'd0, 32'(sink_q.size()));
        finish_run();
    end

endmodule
